/* common/hive_params_pkg.sv */
//**********************************************************************
// hive stack sizes
// default thread count, stack count, word width and stack depth;
// the top level takes these as its parameter defaults
//**********************************************************************

package hive_params_pkg;

	// barrel processor threads, one per pipeline stage
	localparam int THREADS = 8;

	// data stacks per thread
	localparam int STACKS = 8;

	localparam int ALU_W = 32;  // stack word width

	// stack selector width, covers STACKS
	localparam int STK_W = 3;

	// per-thread stack depth in address bits
	// 5 bits gives 32 entries per stack
	localparam int PTR_W = 5;

endpackage

/* common/hive_types_pkg.sv */
//**********************************************************************
// hive shared types
// thread id and the per-stage thread id vector
//**********************************************************************

package hive_types_pkg;

	import hive_params_pkg::*;

	// thread id width, covers THREADS
	localparam int THR_W = 3;

	// one thread id
	typedef logic [THR_W-1:0] thr_t;

	// thread id per pipeline stage
	// element k is the thread currently in stage k
	typedef thr_t [THREADS-1:0] id_t;

endpackage

/* verilog/pipe.sv */
//**********************************************************************
// pipe
// register delay line, DEPTH stages of WIDTH bits, resets to RESET_VAL
//**********************************************************************

module pipe #(
	parameter int               DEPTH,      // stages, at least 1
	parameter int               WIDTH,      // bits per stage
	parameter logic [WIDTH-1:0] RESET_VAL   // value of every stage after reset
) (
	input  logic             clk_i,
	input  logic             rst_i,
	input  logic [WIDTH-1:0] data_i,
	output logic [WIDTH-1:0] data_o    // data_i delayed by DEPTH clocks
);

	logic [WIDTH-1:0] sr [DEPTH];  // stage 0 is the input side

	always_ff @(posedge clk_i or posedge rst_i) begin
		if (rst_i) begin
			for (int i = 0; i < DEPTH; i++) begin
				sr[i] <= RESET_VAL;
			end
		end else begin
			sr[0] <= data_i;
			for (int i = 1; i < DEPTH; i++) begin
				sr[i] <= sr[i-1];  // shift one stage
			end
		end
	end

	assign data_o = sr[DEPTH-1];

endmodule

/* verilog/hive_id_ring.sv */
//**********************************************************************
// hive thread id ring
// rotating thread counter, gives the thread held in each stage
//**********************************************************************

module hive_id_ring
	import hive_types_pkg::*;
#(
	parameter int THREADS
) (
	input  logic clk_i,
	input  logic rst_i,
	output id_t  id_o   // element k is the thread in stage k
);

	thr_t cnt;  // thread entering stage 0

	always_ff @(posedge clk_i or posedge rst_i) begin
		if (rst_i) begin
			cnt <= '0;  // thread 0 in stage 0
		end else begin
			cnt <= (cnt == thr_t'(THREADS - 1)) ? '0 : cnt + 1'b1;
		end
	end

	// stage k holds the thread that was in stage 0 k cycles ago
	always_comb begin
		for (int k = 0; k < THREADS; k++) begin
			id_o[k] = thr_t'((int'(cnt) + THREADS - k) % THREADS);
		end
	end

endmodule

/* hive_stacks/hive_stack_ring.sv */
//**********************************************************************
// hive stack ring
// one LIFO shared by all threads: per-thread levels, one block RAM,
// empty check at stage 1, full check at stage 5, top read at stage 7
//**********************************************************************

module hive_stack_ring
	import hive_types_pkg::*;
#(
	parameter int ALU_W,
	parameter int PTR_W,
	parameter int THREADS
) (
	input  logic             clk_i,
	input  logic             rst_i,
	input  logic             cls_i,       // clear, stage 1
	input  logic             pop_1_i,     // pop, stage 1
	input  logic             psh_5_i,     // push, stage 5
	input  id_t              id_i,        // thread per stage
	input  logic [ALU_W-1:0] data_6_i,    // push word, stage 6
	output logic [ALU_W-1:0] data_o,      // top word, valid at stage 0
	output logic             pop_er_2_o,  // pop when empty, stage 2
	output logic             psh_er_5_o   // push when full, stage 5
);

	localparam int LVL_W = PTR_W + 1;  // level counts 0 to 2**PTR_W
	localparam int ADR_W = THR_W + PTR_W;
	localparam logic [LVL_W-1:0] FULL = LVL_W'(2 ** PTR_W);

	logic [LVL_W-1:0] lvl [THREADS];               // entries held per thread
	logic [ALU_W-1:0] ram [THREADS * (2 ** PTR_W)];  // thread in upper addr bits

	logic [LVL_W-1:0] lvl_1, lvl_2, lvl_5, lvl_6, lvl_7;
	logic [LVL_W-1:0] top_7;   // index of top entry
	logic             pop_ok_2;
	logic             psh_ok_6;
	logic [ADR_W-1:0] wr_adr_6, rd_adr_7;

	// level of the thread in each stage that looks at it
	always_comb lvl_1 = lvl[id_i[1]];
	always_comb lvl_2 = lvl[id_i[2]];
	always_comb lvl_5 = lvl[id_i[5]];
	always_comb lvl_6 = lvl[id_i[6]];
	always_comb lvl_7 = lvl[id_i[7]];

	// stage 1 empty check
	// a clear in the same instruction empties the stack first
	always_ff @(posedge clk_i or posedge rst_i) begin
		if (rst_i) begin
			pop_ok_2   <= 1'b0;
			pop_er_2_o <= 1'b0;
		end else begin
			pop_ok_2   <= pop_1_i & ~cls_i & (lvl_1 != '0);
			pop_er_2_o <= pop_1_i & (cls_i | (lvl_1 == '0));
		end
	end

	// stage 5 full check, sees the pop of this instruction
	always_comb psh_er_5_o = psh_5_i & (lvl_5 == FULL);

	always_ff @(posedge clk_i or posedge rst_i) begin
		if (rst_i) begin
			psh_ok_6 <= 1'b0;
		end else begin
			psh_ok_6 <= psh_5_i & (lvl_5 != FULL);
		end
	end

	// level updates: clear at 1, pop at 2, push at 6
	// the three stages always hold different threads
	always_ff @(posedge clk_i or posedge rst_i) begin
		if (rst_i) begin
			for (int i = 0; i < THREADS; i++) begin
				lvl[i] <= '0;
			end
		end else begin
			if (cls_i) begin
				lvl[id_i[1]] <= '0;
			end
			if (pop_ok_2) begin
				lvl[id_i[2]] <= lvl_2 - 1'b1;
			end
			if (psh_ok_6) begin
				lvl[id_i[6]] <= lvl_6 + 1'b1;
			end
		end
	end

	// push writes one above the current top
	always_comb wr_adr_6 = {id_i[6], lvl_6[PTR_W-1:0]};

	// stage 7 sees the thread's final level
	always_comb top_7    = lvl_7 - 1'b1;  // wraps when empty, word unused then
	always_comb rd_adr_7 = {id_i[7], top_7[PTR_W-1:0]};

	// block RAM, sync write and registered read
	always_ff @(posedge clk_i) begin
		if (psh_ok_6) begin
			ram[wr_adr_6] <= data_6_i;
		end
		data_o <= ram[rd_adr_7];  // ready for stage 0
	end

endmodule

/* hive_stacks/hive_stacks.sv */
//**********************************************************************
// hive stacks
// decodes clear, pop and push onto STACKS stack rings, muxes the
// top words by selector and lines the errors up at stage 8
//**********************************************************************

module hive_stacks
	import hive_types_pkg::*;
#(
	parameter int STACKS,
	parameter int STK_W,
	parameter int ALU_W,
	parameter int PTR_W,
	parameter int THREADS
) (
	input  logic              clk_i,
	input  logic              rst_i,
	input  logic [STACKS-1:0] stk_im_i,   // stack mask
	input  logic              cls_im_i,   // clear masked stacks
	input  logic              pop_im_i,   // pop masked stacks
	input  logic              pop_a_i,    // pop sa_i stack
	input  logic              pop_b_i,    // pop sb_i stack
	input  logic              psh_a_i,    // push onto sa_i stack
	input  id_t               id_i,       // thread per stage
	input  logic [ALU_W-1:0]  data_6_i,   // push word, issue + 6
	input  logic [STK_W-1:0]  sa_i,
	input  logic [STK_W-1:0]  sb_i,
	output logic [ALU_W-1:0]  a_o,        // top of sa_i stack
	output logic [ALU_W-1:0]  b_o,        // top of sb_i stack
	output logic              pop_er_o,   // pop when empty, issue + 8
	output logic              psh_er_o    // push when full, issue + 8
);

	logic [ALU_W-1:0]  data [STACKS];  // top word per stack
	logic [STACKS-1:0] cls_0, cls_1;   // per stack clear
	logic [STACKS-1:0] pop_0, pop_1;   // per stack pop
	logic              psh_a_4;
	logic [STK_W-1:0]  sa_4;
	logic [STACKS-1:0] psh_5;          // per stack push
	logic [STACKS-1:0] pop_er_2;
	logic [STACKS-1:0] psh_er_5;

	// clear and pop decode, a b and mask to one stack merge into one pop
	always_comb cls_0 = cls_im_i ? stk_im_i : '0;
	always_comb pop_0 = (pop_im_i ? stk_im_i : '0)
		| (STACKS'(pop_a_i) << sa_i)
		| (STACKS'(pop_b_i) << sb_i);

	always_ff @(posedge clk_i or posedge rst_i) begin
		if (rst_i) begin
			cls_1 <= '0;
			pop_1 <= '0;
		end else begin
			cls_1 <= cls_0;
			pop_1 <= pop_0;
		end
	end

	// push command waits for stage 4
	pipe #(
		.DEPTH     (4),
		.WIDTH     (1 + STK_W),
		.RESET_VAL ('0)
	) i_psh_pipe (
		.clk_i  (clk_i),
		.rst_i  (rst_i),
		.data_i ({psh_a_i, sa_i}),
		.data_o ({psh_a_4, sa_4})
	);

	always_ff @(posedge clk_i or posedge rst_i) begin
		if (rst_i) begin
			psh_5 <= '0;
		end else begin
			psh_5 <= STACKS'(psh_a_4) << sa_4;  // decode at stage 5
		end
	end

	for (genvar g = 0; g < STACKS; g++) begin : g_stack
		hive_stack_ring #(
			.ALU_W   (ALU_W),
			.PTR_W   (PTR_W),
			.THREADS (THREADS)
		) i_stack_ring (
			.clk_i      (clk_i),
			.rst_i      (rst_i),
			.cls_i      (cls_1[g]),
			.pop_1_i    (pop_1[g]),
			.psh_5_i    (psh_5[g]),
			.id_i       (id_i),
			.data_6_i   (data_6_i),
			.data_o     (data[g]),
			.pop_er_2_o (pop_er_2[g]),
			.psh_er_5_o (psh_er_5[g])
		);
	end

	// top words for the thread in stage 0
	always_comb a_o = data[sa_i];
	always_comb b_o = data[sb_i];

	// pop error, stage 2 to 8
	pipe #(
		.DEPTH     (6),
		.WIDTH     (1),
		.RESET_VAL (1'b0)
	) i_pop_er_pipe (
		.clk_i  (clk_i),
		.rst_i  (rst_i),
		.data_i (|pop_er_2),
		.data_o (pop_er_o)
	);

	// push error, stage 5 to 8
	pipe #(
		.DEPTH     (3),
		.WIDTH     (1),
		.RESET_VAL (1'b0)
	) i_psh_er_pipe (
		.clk_i  (clk_i),
		.rst_i  (rst_i),
		.data_i (|psh_er_5),
		.data_o (psh_er_o)
	);

endmodule

/* verilog/hive_stack_sys.sv */
//**********************************************************************
// hive stack subsystem
// thread id ring driving the per-thread data stacks
//**********************************************************************

module hive_stack_sys
	import hive_types_pkg::*;
#(
	parameter int THREADS = hive_params_pkg::THREADS,
	parameter int STACKS  = hive_params_pkg::STACKS,
	parameter int STK_W   = hive_params_pkg::STK_W,
	parameter int ALU_W   = hive_params_pkg::ALU_W,
	parameter int PTR_W   = hive_params_pkg::PTR_W
) (
	input  logic              clk_i,
	input  logic              rst_i,
	input  logic [STACKS-1:0] stk_im_i,
	input  logic              cls_im_i,
	input  logic              pop_im_i,
	input  logic              pop_a_i,
	input  logic              pop_b_i,
	input  logic              psh_a_i,
	input  logic [ALU_W-1:0]  data_6_i,
	input  logic [STK_W-1:0]  sa_i,
	input  logic [STK_W-1:0]  sb_i,
	output logic [ALU_W-1:0]  a_o,
	output logic [ALU_W-1:0]  b_o,
	output logic              pop_er_o,
	output logic              psh_er_o,
	output thr_t              id_o      // thread in stage 0
);

	id_t id;  // thread per stage

	hive_id_ring #(
		.THREADS (THREADS)
	) i_id_ring (
		.clk_i (clk_i),
		.rst_i (rst_i),
		.id_o  (id)
	);

	hive_stacks #(
		.STACKS  (STACKS),
		.STK_W   (STK_W),
		.ALU_W   (ALU_W),
		.PTR_W   (PTR_W),
		.THREADS (THREADS)
	) i_stacks (
		.clk_i    (clk_i),
		.rst_i    (rst_i),
		.stk_im_i (stk_im_i),
		.cls_im_i (cls_im_i),
		.pop_im_i (pop_im_i),
		.pop_a_i  (pop_a_i),
		.pop_b_i  (pop_b_i),
		.psh_a_i  (psh_a_i),
		.id_i     (id),
		.data_6_i (data_6_i),
		.sa_i     (sa_i),
		.sb_i     (sb_i),
		.a_o      (a_o),
		.b_o      (b_o),
		.pop_er_o (pop_er_o),
		.psh_er_o (psh_er_o)
	);

	assign id_o = id[0];  // inputs apply to this thread

endmodule

/* tb/hive_stack_sys_tb.sv */
//**********************************************************************
// hive stack subsystem testbench
// reference LIFO model per thread and stack, directed and random
// traffic, checks top words, thread ids and error flags
//**********************************************************************

module hive_stack_sys_tb
	import hive_params_pkg::*;
	import hive_types_pkg::*;
();

	localparam int DEPTH   = 2 ** PTR_W;  // entries per stack
	localparam int N_RAND  = 4000;        // random instructions
	localparam int N_DIR   = 1000;        // bound on directed instructions
	localparam int TIMEOUT = ((N_DIR + N_RAND) * 8 + 64) * 8;

	logic              clk_i;
	logic              rst_i;
	logic [STACKS-1:0] stk_im_i;
	logic              cls_im_i, pop_im_i, pop_a_i, pop_b_i, psh_a_i;
	logic [ALU_W-1:0]  data_6_i;
	logic [STK_W-1:0]  sa_i, sb_i;
	logic [ALU_W-1:0]  a_o, b_o;
	logic              pop_er_o, psh_er_o;
	thr_t              id_o;

	logic [ALU_W-1:0] mdl_mem [THREADS][STACKS][DEPTH];  // reference LIFOs
	int               mdl_lvl [THREADS][STACKS];
	logic [1:0]       err_q [$];    // expected {pop, push} error per cycle
	logic [ALU_W-1:0] data_q [$];   // push words waiting for stage 6
	logic [31:0]      lfsr;
	int               cyc;
	int               n_checks;
	thr_t             exp_thr;
	logic [ALU_W-1:0] exp_a, exp_b;
	logic             exp_a_vld, exp_b_vld;  // model stack non-empty

	hive_stack_sys i_hive_stack_sys (
		.clk_i    (clk_i),
		.rst_i    (rst_i),
		.stk_im_i (stk_im_i),
		.cls_im_i (cls_im_i),
		.pop_im_i (pop_im_i),
		.pop_a_i  (pop_a_i),
		.pop_b_i  (pop_b_i),
		.psh_a_i  (psh_a_i),
		.data_6_i (data_6_i),
		.sa_i     (sa_i),
		.sb_i     (sb_i),
		.a_o      (a_o),
		.b_o      (b_o),
		.pop_er_o (pop_er_o),
		.psh_er_o (psh_er_o),
		.id_o     (id_o)
	);

	always #4 clk_i = ~clk_i;  // period 8

	// fibonacci lfsr with taps 32 22 2 1 and one step per bit
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] r;
		logic        fb;
		r = '0;
		for (int i = 0; i < n; i++) begin
			fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
			lfsr = {lfsr[30:0], fb};
			r    = {r[30:0], fb};
		end
		return r;
	endfunction

	function automatic logic [ALU_W-1:0] top_word(input thr_t th, input logic [STK_W-1:0] s);
		if (mdl_lvl[th][s] == 0) begin
			return '0;
		end
		return mdl_mem[th][s][mdl_lvl[th][s] - 1];
	endfunction

	// reference step applies clear, one pop per stack and push in that order
	function automatic logic [1:0] ref_step(input thr_t th, input logic [STACKS-1:0] stk,
		input logic cls, input logic pim, input logic pa, input logic pb, input logic ps,
		input logic [STK_W-1:0] sa, input logic [STK_W-1:0] sb, input logic [ALU_W-1:0] d);
		logic [STACKS-1:0] pop_m;
		logic              pe;
		logic              se;
		pe    = 1'b0;
		se    = 1'b0;
		pop_m = pim ? stk : '0;
		if (pa) pop_m[sa] = 1'b1;  // a b and mask merge
		if (pb) pop_m[sb] = 1'b1;
		for (int s = 0; s < STACKS; s++) begin
			if (cls && stk[s]) mdl_lvl[th][s] = 0;
			if (pop_m[s]) begin
				if (mdl_lvl[th][s] == 0) pe = 1'b1;  // empty keeps the level
				else mdl_lvl[th][s]--;
			end
		end
		if (ps) begin
			if (mdl_lvl[th][sa] == DEPTH) begin
				se = 1'b1;  // full keeps the contents
			end else begin
				mdl_mem[th][sa][mdl_lvl[th][sa]] = d;
				mdl_lvl[th][sa]++;
			end
		end
		return {pe, se};
	endfunction

	task automatic check_word(input string name, input logic [ALU_W-1:0] got,
		input logic [ALU_W-1:0] exp);
		if (got !== exp) begin
			$display("CHECK FAILED %s got 0x%h expected 0x%h at cycle %0d", name, got, exp, cyc);
			$display("Simulation FAILED");
			$fatal(1);
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("CHECK FAILED %s got 0x%h expected 0x%h at cycle %0d", name, got, exp, cyc);
			$display("Simulation FAILED");
			$fatal(1);
		end
	endtask

	task automatic check_id(input string name, input thr_t got, input thr_t exp);
		if (got !== exp) begin
			$display("CHECK FAILED %s got 0x%h expected 0x%h at cycle %0d", name, got, exp, cyc);
			$display("Simulation FAILED");
			$fatal(1);
		end
	endtask

	// one instruction for the thread in stage 0 and a step to the next cycle
	task automatic issue(input logic [STACKS-1:0] stk, input logic cls, input logic pim,
		input logic pa, input logic pb, input logic ps, input int sa, input int sb);
		thr_t             th;
		logic [STK_W-1:0] a;
		logic [STK_W-1:0] b;
		logic [ALU_W-1:0] d;
		th        = thr_t'(cyc % THREADS);
		a         = STK_W'(sa);
		b         = STK_W'(sb);
		d         = rand_bits(ALU_W);
		exp_thr   = th;
		exp_a_vld = mdl_lvl[th][a] != 0;  // state before this instruction
		exp_b_vld = mdl_lvl[th][b] != 0;
		exp_a     = top_word(th, a);
		exp_b     = top_word(th, b);
		err_q.push_back(ref_step(th, stk, cls, pim, pa, pb, ps, a, b, d));
		data_q.push_back(ps ? d : '0);
		stk_im_i = stk;
		cls_im_i = cls;
		pop_im_i = pim;
		pop_a_i  = pa;
		pop_b_i  = pb;
		psh_a_i  = ps;
		sa_i     = a;
		sb_i     = b;
		if (data_q.size() > 6) data_6_i = data_q.pop_front();  // word of six issues back
		else data_6_i = '0;
		cyc++;
		@(posedge clk_i);
		#1;
	endtask

	// compare at the falling edge where outputs are settled
	initial begin : compare
		logic [1:0] e;
		@(negedge rst_i);
		forever begin
			@(negedge clk_i);
			check_id("id_o", id_o, exp_thr);
			if (exp_a_vld) check_word("a_o", a_o, exp_a);
			if (exp_b_vld) check_word("b_o", b_o, exp_b);
			e = 2'b00;  // nothing issued 8 cycles ago yet
			if (err_q.size() > 8) e = err_q.pop_front();
			check_flag("pop_er_o", pop_er_o, e[1]);
			check_flag("psh_er_o", psh_er_o, e[0]);
			n_checks++;
		end
	end

	initial begin : watchdog
		#(TIMEOUT);
		$display("timeout, the test sequence did not finish in the expected time");
		$display("Simulation FAILED");
		$fatal(1);
	end

	initial begin : stimulus
		clk_i    = 1'b0;
		rst_i    = 1'b1;
		stk_im_i = '0;
		cls_im_i = 1'b0;
		pop_im_i = 1'b0;
		pop_a_i  = 1'b0;
		pop_b_i  = 1'b0;
		psh_a_i  = 1'b0;
		data_6_i = '0;
		sa_i     = '0;
		sb_i     = '0;
		lfsr     = 32'h9b8e_9f3d;
		cyc      = 0;
		n_checks = 0;
		for (int t = 0; t < THREADS; t++) begin
			for (int s = 0; s < STACKS; s++) mdl_lvl[t][s] = 0;
		end
		repeat (2) @(posedge clk_i);
		#1;
		rst_i = 1'b0;
		repeat (16) issue('0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 0, 0);  // idle ring
		for (int r = 0; r < STACKS; r++) begin  // every thread fills every stack
			repeat (THREADS) issue('0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1, r, 0);
		end
		for (int r = 0; r < STACKS; r++) begin
			for (int t = 0; t < THREADS; t++) begin
				issue('0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, r, (r + t) % STACKS);
			end
		end
		repeat (3) begin
			for (int t = 0; t < THREADS; t++) issue('0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1, t, t);
		end
		// pops by a and b on one stack then split then by mask
		for (int t = 0; t < THREADS; t++) issue('0, 1'b0, 1'b0, 1'b1, 1'b1, 1'b0, t, t);
		for (int t = 0; t < THREADS; t++) begin
			issue('0, 1'b0, 1'b0, 1'b1, 1'b1, 1'b0, t, (t + 3) % STACKS);
		end
		for (int t = 0; t < THREADS; t++) issue(STACKS'(8'h0f), 1'b0, 1'b1, 1'b0, 1'b0, 1'b0, t, t);
		for (int t = 0; t < THREADS; t++) begin
			issue('0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, t, (t + 3) % STACKS);
		end
		// every stack holds a word again so only the clear can empty one
		for (int r = 0; r < STACKS; r++) begin
			repeat (THREADS) issue('0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1, r, 0);
		end
		for (int t = 0; t < THREADS; t++) issue(STACKS'(8'h55), 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, t, t);
		// popping the cleared stacks errors
		for (int t = 0; t < THREADS; t++) issue(STACKS'(8'h55), 1'b0, 1'b1, 1'b0, 1'b0, 1'b0, t, t);
		for (int t = 0; t < THREADS; t++) begin  // odd stacks keep their words
			issue('0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, t, (t + 1) % STACKS);
		end
		repeat (DEPTH + 1) begin  // overfill the top stack
			repeat (THREADS) issue('0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1, STACKS - 1, 0);
		end
		repeat (THREADS) issue('0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, STACKS - 1, STACKS - 1);
		repeat (THREADS) issue('1, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 0, 0);
		repeat (THREADS) issue('0, 1'b0, 1'b0, 1'b1, 1'b0, 1'b1, STACKS - 1, 0);  // empty pop with push
		repeat (N_RAND) begin
			issue(STACKS'(rand_bits(STACKS)), rand_bits(4) == 0, rand_bits(3) == 0,
				rand_bits(2) == 0, rand_bits(2) == 0, rand_bits(1) == 1,
				int'(rand_bits(2)), int'(rand_bits(STK_W)));
		end
		repeat (9) issue('0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 0, 0);  // drain error pipe
		if (n_checks > 0) begin
			$display("Simulation PASSED");
			$finish;
		end else begin
			$display("no output comparisons were made during the run");
			$display("Simulation FAILED");
			$fatal(1);
		end
	end

endmodule

/* filelist.f */
common/hive_params_pkg.sv
common/hive_types_pkg.sv
verilog/pipe.sv
verilog/hive_id_ring.sv
hive_stacks/hive_stack_ring.sv
hive_stacks/hive_stacks.sv
verilog/hive_stack_sys.sv
tb/hive_stack_sys_tb.sv

/* Bender.yml */
package:
  name: hive_stack_sys

sources:
  - common/hive_params_pkg.sv
  - common/hive_types_pkg.sv
  - verilog/pipe.sv
  - verilog/hive_id_ring.sv
  - hive_stacks/hive_stack_ring.sv
  - hive_stacks/hive_stacks.sv
  - verilog/hive_stack_sys.sv
  - target: test
    files:
      - tb/hive_stack_sys_tb.sv
